/* approx_mul_pkg.sv */
`default_nettype none

package approx_mul_pkg;

    localparam int OPERAND_W = 16;
    localparam int PRODUCT_W = 32;
    localparam int COUNT_W = 16;
    localparam int SUM_W = 48;

    // Rows 0 to APPROX_ROWS-1 are folded into compressed terms in the approximate array.
    localparam int APPROX_ROWS = 6;
    localparam int COMP_TERMS = 4;

    typedef struct packed {
        logic signed [OPERAND_W-1:0] x;
        logic signed [OPERAND_W-1:0] y;
    } sample_t;

    typedef struct packed {
        logic signed [PRODUCT_W-1:0] approx;
        logic signed [PRODUCT_W-1:0] error;
        logic [COUNT_W-1:0]          count;
        logic [PRODUCT_W-1:0]        max_abs_err;
        logic [SUM_W-1:0]            sum_abs_err;
    } stats_t;

    // One row per multiplier bit of x. Bit c of row r has weight r + c.
    typedef logic [OPERAND_W-1:0][OPERAND_W:0] pp_rows_t;

    // Baugh-Wooley partial products with inverted sign terms and the two correction ones.
    function automatic pp_rows_t bw_rows(sample_t s);
        pp_rows_t rows;
        for (int r = 0; r < OPERAND_W; r++) begin
            for (int c = 0; c < OPERAND_W - 1; c++) begin
                rows[r][c] = s.x[r] & s.y[c];
            end
            rows[r][OPERAND_W-1] = ~(s.x[r] & s.y[OPERAND_W-1]);
            rows[r][OPERAND_W] = 1'b0;
        end
        // Last row carries the sign of x.
        for (int c = 0; c < OPERAND_W - 1; c++) begin
            rows[OPERAND_W-1][c] = ~(s.x[OPERAND_W-1] & s.y[c]);
        end
        rows[OPERAND_W-1][OPERAND_W-1] = s.x[OPERAND_W-1] & s.y[OPERAND_W-1];
        // Constant ones land at weight 16 and weight 31.
        rows[0][OPERAND_W] = 1'b1;
        rows[OPERAND_W-1][OPERAND_W] = 1'b1;
        return rows;
    endfunction

endpackage

`default_nettype wire

/* approx_mul_bw16.sv */
`timescale 1ns/100ps
`default_nettype none

module approx_mul_bw16 (
    input  approx_mul_pkg::sample_t                     sample,
    output logic signed [approx_mul_pkg::PRODUCT_W-1:0] product
);

    approx_mul_pkg::pp_rows_t rows;
    logic [approx_mul_pkg::COMP_TERMS-1:0][approx_mul_pkg::PRODUCT_W-1:0] comp;
    logic [approx_mul_pkg::PRODUCT_W-1:0] acc;

    assign rows = approx_mul_pkg::bw_rows(sample);

    // Fixed compression of the low six rows.
    // Each term pairs bits of equal weight from neighboring rows.
    // XOR keeps the sum bit in place and AND moves a carry one weight up.
    always_comb begin
        comp = '0;

        // Rows 0 and 1.
        comp[0][2]  = rows[0][2] ^ rows[1][1];
        comp[0][8]  = rows[0][8] ^ rows[1][7];
        comp[0][11] = rows[0][10] & rows[1][9];
        comp[0][12] = rows[0][11] & rows[1][10];
        comp[0][13] = rows[0][12] & rows[1][11];
        comp[0][14] = rows[0][14] ^ rows[1][13];
        comp[0][15] = rows[0][15] ^ rows[1][14];
        comp[0][17] = rows[1][15];
        comp[1][13] = rows[0][13] ^ rows[1][12];

        // Rows 2 and 3.
        comp[0][5]  = rows[2][2] & rows[3][1];
        comp[0][7]  = rows[2][4] & rows[3][3];
        comp[0][9]  = rows[2][7] ^ rows[3][6];
        comp[0][18] = rows[2][15] & rows[3][14];
        comp[1][8]  = rows[2][6] ^ rows[3][5];
        comp[1][17] = rows[2][15] | rows[3][14];
        comp[1][18] = rows[3][15];
        comp[2][17] = rows[2][15] ^ rows[3][14];

        // Rows 4 and 5.
        comp[0][10] = rows[4][5] & rows[5][4];
        comp[0][19] = rows[4][14] & rows[5][13];
        comp[0][20] = rows[4][15] & rows[5][14];
        comp[1][9]  = rows[4][5] ^ rows[5][4];
        comp[1][12] = rows[4][8] ^ rows[5][7];
        comp[1][19] = rows[4][15] ^ rows[5][14];
        comp[1][20] = rows[5][15];
        comp[2][13] = rows[4][8] & rows[5][7];
        comp[2][18] = rows[4][13] & rows[5][12];
        comp[3][17] = rows[4][13] ^ rows[5][12];
        comp[3][18] = rows[4][14] ^ rows[5][13];
    end

    // Upper rows are summed exactly on top of the compressed terms.
    always_comb begin
        acc = '0;
        for (int t = 0; t < approx_mul_pkg::COMP_TERMS; t++) begin
            acc = acc + comp[t];
        end
        for (int r = approx_mul_pkg::APPROX_ROWS; r < approx_mul_pkg::OPERAND_W; r++) begin
            acc = acc + (approx_mul_pkg::PRODUCT_W'(rows[r]) << r);
        end
    end

    assign product = signed'(acc);

endmodule

`default_nettype wire

/* exact_mul_bw16.sv */
`timescale 1ns/100ps
`default_nettype none

module exact_mul_bw16 (
    input  approx_mul_pkg::sample_t                     sample,
    output logic signed [approx_mul_pkg::PRODUCT_W-1:0] product
);

    approx_mul_pkg::pp_rows_t rows;
    logic [approx_mul_pkg::PRODUCT_W-1:0] even_sum;
    logic [approx_mul_pkg::PRODUCT_W-1:0] odd_sum;

    assign rows = approx_mul_pkg::bw_rows(sample);

    // Two interleaved partial sums that one final adder merges.
    always_comb begin
        even_sum = '0;
        odd_sum = '0;
        for (int r = 0; r < approx_mul_pkg::OPERAND_W; r += 2) begin
            even_sum = even_sum + (approx_mul_pkg::PRODUCT_W'(rows[r]) << r);
            odd_sum = odd_sum + (approx_mul_pkg::PRODUCT_W'(rows[r+1]) << (r + 1));
        end
    end

    // Modulo 2^32 the correction ones turn this into the two's-complement product.
    assign product = signed'(even_sum + odd_sum);

endmodule

`default_nettype wire

/* mul_error_stats.sv */
`timescale 1ns/100ps
`default_nettype none

module mul_error_stats (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        in_valid,
    input  logic signed [approx_mul_pkg::PRODUCT_W-1:0] approx_product,
    input  logic signed [approx_mul_pkg::PRODUCT_W-1:0] exact_product,
    output logic                                        out_valid,
    output approx_mul_pkg::stats_t                      stats
);

    logic signed [approx_mul_pkg::PRODUCT_W-1:0] error;
    logic [approx_mul_pkg::PRODUCT_W-1:0]        abs_err;
    logic                                        new_max;

    assign error = exact_product - approx_product;

    // The magnitude is unsigned so the most negative error still reads correctly.
    assign abs_err = error[approx_mul_pkg::PRODUCT_W-1] ? -error : error;

    assign new_max = abs_err > stats.max_abs_err;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stats <= '0;
        end else if (in_valid) begin
            stats.approx <= approx_product;
            stats.error <= error;
            // Counters wrap.
            stats.count <= stats.count + 1'b1;
            if (new_max) begin
                stats.max_abs_err <= abs_err;
            end
            stats.sum_abs_err <= stats.sum_abs_err + approx_mul_pkg::SUM_W'(abs_err);
        end
    end

endmodule

`default_nettype wire

/* approx_mul_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module approx_mul_monitor (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  approx_mul_pkg::sample_t sample,
    output logic                    out_valid,
    output approx_mul_pkg::stats_t  stats
);

    logic signed [approx_mul_pkg::PRODUCT_W-1:0] approx_product;
    logic signed [approx_mul_pkg::PRODUCT_W-1:0] exact_product;

    // Both arrays see the same operands in the same cycle.
    approx_mul_bw16 u_approx_mul (
        .sample  (sample),
        .product (approx_product)
    );

    exact_mul_bw16 u_exact_mul (
        .sample  (sample),
        .product (exact_product)
    );

    mul_error_stats u_error_stats (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .approx_product (approx_product),
        .exact_product  (exact_product),
        .out_valid      (out_valid),
        .stats          (stats)
    );

endmodule

`default_nettype wire

/* approx_mul_monitor_props.sv */
`timescale 1ns/100ps
`default_nettype none

module approx_mul_monitor_props (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    in_valid,
    input approx_mul_pkg::sample_t sample,
    input logic                    out_valid,
    input approx_mul_pkg::stats_t  stats
);

    // Count of failed assertions.
    int unsigned fail_count = 0;

    // Two's-complement product of the operand pair after sign extension to 32 bits.
    function automatic logic signed [approx_mul_pkg::PRODUCT_W-1:0] true_product(
        approx_mul_pkg::sample_t s
    );
        logic signed [approx_mul_pkg::PRODUCT_W-1:0] a;
        logic signed [approx_mul_pkg::PRODUCT_W-1:0] b;
        a = s.x;
        b = s.y;
        return a * b;
    endfunction

    function automatic logic [approx_mul_pkg::PRODUCT_W-1:0] magnitude(
        logic signed [approx_mul_pkg::PRODUCT_W-1:0] v
    );
        return (v < 0) ? -v : v;
    endfunction

    function automatic logic [approx_mul_pkg::PRODUCT_W-1:0] larger(
        logic [approx_mul_pkg::PRODUCT_W-1:0] a,
        logic [approx_mul_pkg::PRODUCT_W-1:0] b
    );
        return (a > b) ? a : b;
    endfunction

    latency_high: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |=> out_valid)
        else begin
            $error("out_valid not high one cycle after in_valid");
            fail_count++;
        end

    latency_low: assert property (@(posedge clk) disable iff (!rst_n)
        !in_valid |=> !out_valid)
        else begin
            $error("out_valid high without a sample one cycle earlier");
            fail_count++;
        end

    // Approximate product plus error gives back the exact product.
    error_sum: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (stats.approx + stats.error) == $past(true_product(sample)))
        else begin
            $error("approx plus error differs from the true product");
            fail_count++;
        end

    count_step: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> stats.count == approx_mul_pkg::COUNT_W'($past(stats.count) + 1'b1))
        else begin
            $error("sample count did not step by one");
            fail_count++;
        end

    stats_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> $stable(stats))
        else begin
            $error("statistics changed without a result");
            fail_count++;
        end

    max_rule: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> stats.max_abs_err ==
            larger($past(stats.max_abs_err), magnitude(stats.error)))
        else begin
            $error("largest absolute error is wrong");
            fail_count++;
        end

    max_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        stats.max_abs_err >= $past(stats.max_abs_err))
        else begin
            $error("largest absolute error decreased");
            fail_count++;
        end

    sum_rule: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> stats.sum_abs_err ==
            $past(stats.sum_abs_err) + approx_mul_pkg::SUM_W'(magnitude(stats.error)))
        else begin
            $error("sum of absolute errors is wrong");
            fail_count++;
        end

    // First cycle out of reset.
    reset_clear: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(rst_n) |-> !out_valid && stats == '0)
        else begin
            $error("outputs not cleared after reset");
            fail_count++;
        end

endmodule

`default_nettype wire

/* tb_approx_mul_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_approx_mul_monitor;

    logic                    clk;
    logic                    rst_n;
    logic                    in_valid;
    approx_mul_pkg::sample_t sample;
    logic                    out_valid;
    approx_mul_pkg::stats_t  stats;

    // Phase lengths in cycles.
    int reset_cycles = 5;
    int directed_cycles = 10;
    int random_cycles = 600;
    int midrun_cycles = 4;
    int tail_cycles = 3;
    int cycle_limit;
    int cycle_count = 0;

    logic signed [approx_mul_pkg::OPERAND_W-1:0] dir_x [5] = '{0, 1, -1, -32768, 32767};
    logic signed [approx_mul_pkg::OPERAND_W-1:0] dir_y [5] = '{-5321, -1234, 32767, -32768, -32768};

    approx_mul_monitor UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .sample    (sample),
        .out_valid (out_valid),
        .stats     (stats)
    );

    bind approx_mul_monitor approx_mul_monitor_props u_props (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles.", cycle_limit);
            $display("tests failed");
            $fatal(1, "timeout");
        end
    end

    // Stop at the first failed assertion.
    initial begin
        wait (UUT.u_props.fail_count != 0);
        $display("[ERROR] time %0t: an assertion on the results failed", $time);
        $display("tests failed");
        $fatal(1, "assertion failure");
    end

    task automatic send_sample(
        input logic signed [approx_mul_pkg::OPERAND_W-1:0] x,
        input logic signed [approx_mul_pkg::OPERAND_W-1:0] y,
        input logic                                        valid
    );
        @(posedge clk);
        in_valid <= valid;
        sample.x <= x;
        sample.y <= y;
    endtask

    // Holds rst_n low for three sampled edges.
    task automatic pulse_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        in_valid <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    initial begin
        logic [31:0] rnd;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        sample = '0;
        cycle_limit = 2 * (reset_cycles + directed_cycles + random_cycles
                           + midrun_cycles + tail_cycles);
        void'($urandom(32'hf5d4_b089));

        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < 5; i++) begin
            send_sample(dir_x[i], dir_y[i], 1'b1);
            send_sample('0, '0, 1'b0);
        end

        for (int i = 0; i < random_cycles; i++) begin
            if (i == random_cycles / 2) begin
                pulse_reset();
            end
            rnd = $urandom();
            send_sample(rnd[31:16], rnd[15:0], $urandom_range(0, 3) != 0);
        end

        repeat (tail_cycles) begin
            send_sample('0, '0, 1'b0);
        end
        @(negedge clk);

        if (UUT.u_props.fail_count == 0) begin
            $display("all tests passed");
            $finish;
        end else begin
            $display("tests failed");
            $fatal(1, "assertion failures");
        end
    end

endmodule

`default_nettype wire

/* src.f */
approx_mul_pkg.sv
approx_mul_bw16.sv
exact_mul_bw16.sv
mul_error_stats.sv
approx_mul_monitor.sv
approx_mul_monitor_props.sv
tb_approx_mul_monitor.sv

/* Bender.yml */
package:
  name: approx_mul_monitor

sources:
  - approx_mul_pkg.sv
  - approx_mul_bw16.sv
  - exact_mul_bw16.sv
  - mul_error_stats.sv
  - approx_mul_monitor.sv
  - target: test
    files:
      - approx_mul_monitor_props.sv
      - tb_approx_mul_monitor.sv
